//--- include/id_macros.svh
/*
 * Width, opcode and instruction step constants for the RV32I decode stage
 */
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// Data word and register index widths
`define ID_XLEN       32
`define ID_REG_AW     5

// Byte step to the next instruction, no compressed support
`define ID_INSN_STEP  4

// Major opcodes, instr[6:0]
`define ID_OPC_OP     7'b0110011
`define ID_OPC_OP_IMM 7'b0010011
`define ID_OPC_LUI    7'b0110111
`define ID_OPC_AUIPC  7'b0010111
`define ID_OPC_LOAD   7'b0000011
`define ID_OPC_STORE  7'b0100011
`define ID_OPC_BRANCH 7'b1100011
`define ID_OPC_JAL    7'b1101111

`endif

//--- rtl/id_pkg.sv
/*
 * Types of the decode stage: word and index vectors, select and FSM enums,
 * decode struct and LSU request struct
 */
`include "id_macros.svh"

package id_pkg;

  // Plain vectors with a meaning
  typedef logic [`ID_XLEN-1:0]   word_t;
  typedef logic [31:0]           insn_t;
  typedef logic [`ID_REG_AW-1:0] reg_addr_t;

  // ALU operations, compares used by branches
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand selects
  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  // Write-back source
  typedef enum logic {RF_WD_EX, RF_WD_LSU} rf_wd_sel_e;

  // ID FSM
  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

  // Access size, matches the LSU encoding
  typedef enum logic [1:0] {LSU_WORD = 2'b00, LSU_HALF = 2'b01, LSU_BYTE = 2'b10} lsu_type_e;

  // Everything the decoder derives from one instruction
  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    rf_wd_sel_e rf_wd_sel;
    logic       rf_we;
    logic       rf_ren_a;
    logic       rf_ren_b;
    logic       lsu_req;
    logic       lsu_we;
    lsu_type_e  lsu_type;
    logic       lsu_sign_ext;
    logic       branch;
    logic       jump;
    logic       illegal;
  } decode_t;

  // Request payload, qualified by lsu_req_o
  typedef struct packed {
    logic      we;
    lsu_type_e dtype;
    logic      sign_ext;
    word_t     wdata;
  } lsu_req_t;

endpackage

//--- rtl/id_decoder.sv
/*
 * RV32I instruction decoder
 * Fills the decode struct and selects the sign-extended immediate
 */
`timescale 1ns/100ps
`include "id_macros.svh"

module id_decoder import id_pkg::*; (
  input  insn_t     instr_i,
  input  logic      first_cycle_i,
  output decode_t   dec_o,
  output word_t     imm_o,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output reg_addr_t rf_waddr_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i_type, imm_s_type, imm_b_type, imm_u_type, imm_j_type;
  decode_t    dec;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register indices straight from the fixed fields
  assign rf_raddr_a_o = instr_i[19:15];
  assign rf_raddr_b_o = instr_i[24:20];
  assign rf_waddr_o   = instr_i[11:7];

  ////////////////////
  // Immediates
  ////////////////////
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  ////////////////////
  // Opcode decode
  ////////////////////
  always_comb begin
    dec           = '0;
    dec.alu_op    = ALU_ADD;
    dec.op_a_sel  = OP_A_REG_A;
    dec.op_b_sel  = OP_B_IMM;
    dec.imm_b_sel = IMM_B_I;
    dec.rf_wd_sel = RF_WD_EX;
    dec.lsu_type  = LSU_WORD;

    case (opcode)
      `ID_OPC_OP: begin
        dec.rf_ren_a = 1'b1;
        dec.rf_ren_b = 1'b1;
        dec.rf_we    = 1'b1;
        dec.op_b_sel = OP_B_REG_B;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec.alu_op = ALU_ADD;
          {7'h20, 3'b000}: dec.alu_op = ALU_SUB;
          {7'h00, 3'b001}: dec.alu_op = ALU_SLL;
          {7'h00, 3'b010}: dec.alu_op = ALU_SLT;
          {7'h00, 3'b011}: dec.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: dec.alu_op = ALU_XOR;
          {7'h00, 3'b101}: dec.alu_op = ALU_SRL;
          {7'h20, 3'b101}: dec.alu_op = ALU_SRA;
          {7'h00, 3'b110}: dec.alu_op = ALU_OR;
          {7'h00, 3'b111}: dec.alu_op = ALU_AND;
          default:         dec.illegal = 1'b1;
        endcase
      end
      `ID_OPC_OP_IMM: begin
        dec.rf_ren_a = 1'b1;
        dec.rf_we    = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = ALU_ADD;
          3'b010:  dec.alu_op = ALU_SLT;
          3'b011:  dec.alu_op = ALU_SLTU;
          3'b100:  dec.alu_op = ALU_XOR;
          3'b110:  dec.alu_op = ALU_OR;
          3'b111:  dec.alu_op = ALU_AND;
          3'b001: begin
            dec.alu_op  = ALU_SLL;
            dec.illegal = (funct7 != 7'h00);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            dec.alu_op  = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            dec.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      `ID_OPC_LUI: begin
        dec.op_a_sel  = OP_A_ZERO;
        dec.imm_b_sel = IMM_B_U;
        dec.rf_we     = 1'b1;
      end
      `ID_OPC_AUIPC: begin
        dec.op_a_sel  = OP_A_CURRPC;
        dec.imm_b_sel = IMM_B_U;
        dec.rf_we     = 1'b1;
      end
      `ID_OPC_LOAD: begin
        // Address is rs1 plus I-immediate
        dec.rf_ren_a     = 1'b1;
        dec.rf_we        = 1'b1;
        dec.rf_wd_sel    = RF_WD_LSU;
        dec.lsu_req      = 1'b1;
        dec.lsu_sign_ext = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: dec.lsu_type = LSU_BYTE;
          3'b001, 3'b101: dec.lsu_type = LSU_HALF;
          3'b010:         dec.lsu_type = LSU_WORD;
          default:        dec.illegal  = 1'b1;
        endcase
      end
      `ID_OPC_STORE: begin
        dec.rf_ren_a  = 1'b1;
        dec.rf_ren_b  = 1'b1;
        dec.imm_b_sel = IMM_B_S;
        dec.lsu_req   = 1'b1;
        dec.lsu_we    = 1'b1;
        case (funct3)
          3'b000:  dec.lsu_type = LSU_BYTE;
          3'b001:  dec.lsu_type = LSU_HALF;
          3'b010:  dec.lsu_type = LSU_WORD;
          default: dec.illegal  = 1'b1;
        endcase
      end
      `ID_OPC_BRANCH: begin
        dec.branch   = 1'b1;
        dec.rf_ren_a = 1'b1;
        dec.rf_ren_b = 1'b1;
        if (first_cycle_i) begin
          // Compare rs1 against rs2
          dec.op_b_sel = OP_B_REG_B;
          case (funct3)
            3'b000:  dec.alu_op = ALU_EQ;
            3'b001:  dec.alu_op = ALU_NE;
            3'b100:  dec.alu_op = ALU_LT;
            3'b101:  dec.alu_op = ALU_GE;
            3'b110:  dec.alu_op = ALU_LTU;
            3'b111:  dec.alu_op = ALU_GEU;
            default: dec.illegal = 1'b1;
          endcase
        end else begin
          // Target is PC plus B-immediate
          dec.op_a_sel  = OP_A_CURRPC;
          dec.imm_b_sel = IMM_B_B;
          dec.illegal   = (funct3 == 3'b010) || (funct3 == 3'b011);
        end
      end
      `ID_OPC_JAL: begin
        // Target first, then link value PC + step
        dec.jump      = 1'b1;
        dec.rf_we     = 1'b1;
        dec.op_a_sel  = OP_A_CURRPC;
        dec.imm_b_sel = first_cycle_i ? IMM_B_J : IMM_B_INCR_PC;
      end
      default: dec.illegal = 1'b1;
    endcase

    // Illegal encodings request nothing
    if (dec.illegal) begin
      dec.rf_we    = 1'b0;
      dec.rf_ren_a = 1'b0;
      dec.rf_ren_b = 1'b0;
      dec.lsu_req  = 1'b0;
      dec.lsu_we   = 1'b0;
      dec.branch   = 1'b0;
      dec.jump     = 1'b0;
    end
  end

  assign dec_o = dec;

  // Immediate for operand B
  always_comb begin
    unique case (dec.imm_b_sel)
      IMM_B_I:       imm_o = imm_i_type;
      IMM_B_S:       imm_o = imm_s_type;
      IMM_B_B:       imm_o = imm_b_type;
      IMM_B_U:       imm_o = imm_u_type;
      IMM_B_J:       imm_o = imm_j_type;
      default:       imm_o = word_t'(`ID_INSN_STEP);
    endcase
  end

  // Multi-cycle classes are mutually exclusive
  always_comb begin
    assert ($onehot0({dec.branch, dec.jump, dec.lsu_req}))
      else $error("decoder: branch, jump and LSU request overlap");
  end

endmodule

//--- rtl/id_operand_mux.sv
/*
 * ALU operand, store data and register write-data selection
 */
`timescale 1ns/100ps

module id_operand_mux import id_pkg::*; (
  input  decode_t dec_i,
  input  word_t   imm_i,
  input  word_t   pc_i,
  input  word_t   rf_rdata_a_i,
  input  word_t   rf_rdata_b_i,
  input  word_t   result_ex_i,
  input  word_t   lsu_rdata_i,
  output word_t   alu_op_a_o,
  output word_t   alu_op_b_o,
  output alu_op_e alu_operator_o,
  output word_t   store_data_o,
  output word_t   rf_wdata_o
);

  ////////////////////
  // ALU operands
  ////////////////////

  // Operand A from rs1, current PC or zero for LUI
  always_comb begin
    unique case (dec_i.op_a_sel)
      OP_A_REG_A:  alu_op_a_o = rf_rdata_a_i;
      OP_A_CURRPC: alu_op_a_o = pc_i;
      OP_A_ZERO:   alu_op_a_o = '0;
      default:     alu_op_a_o = '0;
    endcase
  end

  // Operand B from rs2 or the selected immediate
  assign alu_op_b_o = (dec_i.op_b_sel == OP_B_IMM) ? imm_i : rf_rdata_b_i;

  assign alu_operator_o = dec_i.alu_op;

  // No forwarding, store data is rs2 from the register file
  assign store_data_o = rf_rdata_b_i;

  ////////////////////
  // Write-back data
  ////////////////////
  assign rf_wdata_o = (dec_i.rf_wd_sel == RF_WD_LSU) ? lsu_rdata_i : result_ex_i;

  // Decoder only emits the three defined operand-A sources
  always_comb begin
    assert (dec_i.op_a_sel inside {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO})
      else $error("operand mux: undefined operand A select");
  end

endmodule

//--- rtl/id_controller.sv
/*
 * ID FSM with stall logic, branch and jump PC set,
 * LSU four-phase req/ack sequence and instruction completion
 */
`timescale 1ns/100ps

module id_controller import id_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     instr_valid_i,
  input  decode_t  dec_i,
  input  logic     branch_decision_i,
  input  word_t    store_data_i,
  input  logic     lsu_ack_i,
  output logic     first_cycle_o,
  output logic     instr_done_o,
  output logic     id_in_ready_o,
  output logic     pc_set_o,
  output logic     pc_sel_o,
  output logic     rf_we_o,
  output logic     rf_ren_a_o,
  output logic     rf_ren_b_o,
  output logic     illegal_insn_o,
  output logic     lsu_req_o,
  output lsu_req_t lsu_req_data_o
);

  id_fsm_e  id_fsm_q, id_fsm_d;
  logic     first_cycle, legal;
  logic     lsu_dec, branch_dec, jump_dec;
  logic     stall_mem, stall_branch, stall_jump, stall_id;
  logic     branch_set_d, branch_set_q, jump_set;
  logic     pc_set_done_q, instr_done, multicycle_done;
  logic     lsu_start, lsu_req_q;
  lsu_req_t lsu_data_d, lsu_data_q;

  // Qualified decode classes
  assign legal      = ~dec_i.illegal;
  assign lsu_dec    = dec_i.lsu_req & legal;
  assign branch_dec = dec_i.branch & legal;
  assign jump_dec   = dec_i.jump & legal;

  assign first_cycle = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  ////////////////////
  // ID FSM
  ////////////////////
  always_comb begin
    id_fsm_d     = id_fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set     = 1'b0;
    if (instr_valid_i) begin
      unique case (id_fsm_q)
        FIRST_CYCLE: begin
          if (lsu_dec) begin
            // Held here while a stale ack is still high
            if (lsu_start) begin
              id_fsm_d = MULTI_CYCLE;
            end
          end else if (branch_dec) begin
            // Taken branch sets the PC from a register next cycle
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
          end else if (jump_dec) begin
            stall_jump = 1'b1;
            jump_set   = 1'b1;
            id_fsm_d   = MULTI_CYCLE;
          end
        end
        MULTI_CYCLE: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end
        end
        default: id_fsm_d = FIRST_CYCLE;
      endcase
    end
  end

  // Branch and jump end in their second cycle, memory ops on ack
  assign multicycle_done = lsu_dec ? lsu_ack_i : 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q      <= FIRST_CYCLE;
      branch_set_q  <= 1'b0;
      pc_set_done_q <= 1'b0;
      lsu_req_q     <= 1'b0;
    end else begin
      if (instr_valid_i) begin
        id_fsm_q <= id_fsm_d;
      end
      branch_set_q  <= branch_set_d;
      // PC set seen for the current instruction
      pc_set_done_q <= (pc_set_o | pc_set_done_q) & ~instr_done;
      // Request held until ack, dropped the cycle after
      if (lsu_start) begin
        lsu_req_q <= 1'b1;
      end else if (lsu_ack_i) begin
        lsu_req_q <= 1'b0;
      end
    end
  end

  ////////////////////
  // Stall and done
  ////////////////////
  assign stall_mem  = instr_valid_i & lsu_dec & (first_cycle | ~lsu_ack_i);
  assign stall_id   = stall_mem | stall_branch | stall_jump;
  assign instr_done = instr_valid_i & ~stall_id;

  assign instr_done_o  = instr_done;
  assign id_in_ready_o = instr_done;
  assign first_cycle_o = first_cycle;

  // One PC set per instruction, 1 selects the jump target
  assign pc_set_o = (branch_set_q | jump_set) & ~pc_set_done_q;
  assign pc_sel_o = jump_set;

  assign rf_we_o        = instr_done & dec_i.rf_we & legal;
  assign rf_ren_a_o     = instr_valid_i & legal & dec_i.rf_ren_a;
  assign rf_ren_b_o     = instr_valid_i & legal & dec_i.rf_ren_b;
  assign illegal_insn_o = instr_valid_i & dec_i.illegal;

  ////////////////////
  // LSU request
  ////////////////////
  assign lsu_start = first_cycle & lsu_dec & ~lsu_ack_i;

  assign lsu_data_d = '{we:       dec_i.lsu_we,
                        dtype:    dec_i.lsu_type,
                        sign_ext: dec_i.lsu_sign_ext,
                        wdata:    store_data_i};

  // Payload captured with the rising request
  always_ff @(posedge clk_i) begin
    if (lsu_start) begin
      lsu_data_q <= lsu_data_d;
    end
  end

  assign lsu_req_o      = lsu_start | lsu_req_q;
  assign lsu_req_data_o = lsu_req_q ? lsu_data_q : lsu_data_d;

  ////////////////////
  // Assertions
  ////////////////////
  a_multi_needs_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i && (id_fsm_q == FIRST_CYCLE) && (id_fsm_d == MULTI_CYCLE) |-> stall_id)
    else $error("controller: MULTI_CYCLE entered without stall");

  a_req_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_o && !lsu_ack_i |=> lsu_req_o)
    else $error("controller: lsu_req_o dropped before ack");

  a_illegal_no_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_o |-> !stall_id)
    else $error("controller: illegal instruction stalled");

endmodule

//--- rtl/id_stage.sv
/*
 * Decode stage top: decoder, operand mux and controller
 */
`timescale 1ns/100ps

module id_stage import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // From IF
  input  logic      instr_valid_i,
  input  insn_t     instr_i,
  input  word_t     pc_id_i,
  // From EX
  input  logic      branch_decision_i,
  input  word_t     result_ex_i,
  // Register file
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output reg_addr_t rf_waddr_o,
  output logic      rf_ren_a_o,
  output logic      rf_ren_b_o,
  output logic      rf_we_o,
  output word_t     rf_wdata_o,
  // To EX
  output word_t     alu_op_a_o,
  output word_t     alu_op_b_o,
  output alu_op_e   alu_operator_o,
  // Control
  output logic      first_cycle_o,
  output logic      instr_done_o,
  output logic      id_in_ready_o,
  output logic      pc_set_o,
  output logic      pc_sel_o,
  output logic      illegal_insn_o,
  // LSU
  input  logic      lsu_ack_i,
  input  word_t     lsu_rdata_i,
  output logic      lsu_req_o,
  output lsu_req_t  lsu_req_data_o
);

  decode_t dec;
  word_t   imm;
  word_t   store_data;
  logic    first_cycle;

  id_decoder u_decoder (
    .instr_i(instr_i), .first_cycle_i(first_cycle), .dec_o(dec), .imm_o(imm),
    .rf_raddr_a_o(rf_raddr_a_o), .rf_raddr_b_o(rf_raddr_b_o), .rf_waddr_o(rf_waddr_o)
  );

  id_operand_mux u_operand_mux (
    .dec_i(dec), .imm_i(imm), .pc_i(pc_id_i),
    .rf_rdata_a_i(rf_rdata_a_i), .rf_rdata_b_i(rf_rdata_b_i),
    .result_ex_i(result_ex_i), .lsu_rdata_i(lsu_rdata_i),
    .alu_op_a_o(alu_op_a_o), .alu_op_b_o(alu_op_b_o), .alu_operator_o(alu_operator_o),
    .store_data_o(store_data), .rf_wdata_o(rf_wdata_o)
  );

  id_controller u_controller (
    .clk_i(clk_i), .rst_ni(rst_ni), .instr_valid_i(instr_valid_i), .dec_i(dec),
    .branch_decision_i(branch_decision_i), .store_data_i(store_data), .lsu_ack_i(lsu_ack_i),
    .first_cycle_o(first_cycle), .instr_done_o(instr_done_o), .id_in_ready_o(id_in_ready_o),
    .pc_set_o(pc_set_o), .pc_sel_o(pc_sel_o), .rf_we_o(rf_we_o),
    .rf_ren_a_o(rf_ren_a_o), .rf_ren_b_o(rf_ren_b_o), .illegal_insn_o(illegal_insn_o),
    .lsu_req_o(lsu_req_o), .lsu_req_data_o(lsu_req_data_o)
  );

  // First-cycle flag also goes out for EX and the testbench
  assign first_cycle_o = first_cycle;

endmodule

//--- dv/tb_id_stage.sv
/*
 * Testbench for the decode stage: clock, reset, stimulus,
 * register file and LSU models, checking assertions and watchdog
 */
`timescale 1ns/100ps
`include "id_macros.svh"

module tb_id_stage import id_pkg::*; ();

  localparam int N_ALU      = 40;
  localparam int N_ILL      = 20;
  localparam int N_BR       = 20;
  localparam int N_JAL      = 12;
  localparam int N_LSU      = 24;
  localparam int N_TOTAL    = N_ALU + N_ILL + N_BR + N_JAL + N_LSU;
  localparam int RST_CYCLES = 5;

  // Test modes, qualify the checks
  localparam int T_IDLE  = 0;
  localparam int T_ALU   = 1;
  localparam int T_ILL   = 2;
  localparam int T_BR_NT = 3;
  localparam int T_BR_T  = 4;
  localparam int T_JAL   = 5;
  localparam int T_LD    = 6;
  localparam int T_ST    = 7;

  // DUT inputs
  logic      clk_i, rst_ni, instr_valid_i, branch_decision_i, lsu_ack_i;
  insn_t     instr_i;
  word_t     pc_id_i, result_ex_i, rf_rdata_a_i, rf_rdata_b_i, lsu_rdata_i;
  // DUT outputs
  reg_addr_t rf_raddr_a_o, rf_raddr_b_o, rf_waddr_o;
  logic      rf_ren_a_o, rf_ren_b_o, rf_we_o, first_cycle_o, instr_done_o;
  logic      id_in_ready_o, pc_set_o, pc_sel_o, illegal_insn_o, lsu_req_o;
  word_t     rf_wdata_o, alu_op_a_o, alu_op_b_o;
  alu_op_e   alu_operator_o;
  lsu_req_t  lsu_req_data_o;

  // Expected values and bookkeeping
  integer    seed;
  int        mode, ack_delay, err_cnt, insn_cnt, tests_run;
  logic      rst_chk;
  word_t     exp_a, exp_b, exp_store, exp_rdata, exp_wdata;
  alu_op_e   exp_op;
  reg_addr_t exp_rd;
  logic      exp_ren_b, exp_sext;
  lsu_type_e exp_dtype;

  id_stage dut0 (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////
  // Reference models
  ////////////////////

  // Register file returns its index in every byte
  function automatic word_t rf_word(input reg_addr_t a);
    return {4{3'b000, a}};
  endfunction

  function automatic word_t i_type_imm(input insn_t ins);
    return {{20{ins[31]}}, ins[31:20]};
  endfunction

  // JAL offset, bit 0 always zero
  function automatic word_t j_type_imm(input insn_t ins);
    return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  endfunction

  // RV32I operation for funct3, alt marks SUB or SRA
  function automatic alu_op_e alu_op_for(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Access size from the low funct3 bits
  function automatic lsu_type_e lsu_size(input logic [1:0] sz);
    case (sz)
      2'b00:   return LSU_BYTE;
      2'b01:   return LSU_HALF;
      default: return LSU_WORD;
    endcase
  endfunction

  assign rf_rdata_a_i = rf_word(rf_raddr_a_o);
  assign rf_rdata_b_i = rf_word(rf_raddr_b_o);

  // LSU acks after ack_delay cycles, drops ack once req is low
  initial begin : lsu_responder
    int   wait_cnt;
    logic req_smp;
    lsu_ack_i = 1'b0;
    wait_cnt  = 0;
    forever begin
      @(posedge clk_i);
      req_smp = lsu_req_o;
      @(negedge clk_i);
      if (!req_smp) begin
        lsu_ack_i = 1'b0;
        wait_cnt  = 0;
      end else if (!lsu_ack_i) begin
        wait_cnt++;
        if (wait_cnt >= ack_delay) lsu_ack_i = 1'b1;
      end
    end
  end

  ////////////////////
  // Reporting
  ////////////////////
  task automatic report_mismatch(input string sig, input word_t got, input word_t want);
    err_cnt++;
    $display("MISMATCH %s got %h expected %h at %0t", sig, got, want, $time);
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("ERROR %s at %0t", what, $time);
  endtask

  task automatic report_test(input string name, input int n, input int e0);
    tests_run++;
    $display("test %s done: %0d instructions, %0d errors", name, n, err_cnt - e0);
  endtask

  ////////////////////
  // Checks
  ////////////////////
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_chk |-> !pc_set_o && !lsu_req_o && !rf_we_o && !instr_done_o)
    else report_error("control output active in or right after reset");

  a_ready_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    id_in_ready_o == instr_done_o)
    else report_mismatch("id_in_ready_o", 32'(id_in_ready_o), 32'(instr_done_o));

  a_we_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_we_o |-> instr_done_o && !illegal_insn_o)
    else report_error("register write without a legal completed instruction");

  a_pc_set_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_o |=> !pc_set_o)
    else report_error("pc_set_o high for more than one cycle");

  // ALU, operands and same-cycle completion
  a_alu_op_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_ALU) && instr_valid_i |-> alu_op_a_o == exp_a)
    else report_mismatch("alu_op_a_o", alu_op_a_o, exp_a);

  a_alu_op_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_ALU) && instr_valid_i |-> alu_op_b_o == exp_b)
    else report_mismatch("alu_op_b_o", alu_op_b_o, exp_b);

  a_alu_operator: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_ALU) && instr_valid_i |-> alu_operator_o == exp_op)
    else report_mismatch("alu_operator_o", 32'(alu_operator_o), 32'(exp_op));

  a_alu_wdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_ALU) && rf_we_o |-> rf_wdata_o == exp_wdata)
    else report_mismatch("rf_wdata_o", rf_wdata_o, exp_wdata);

  a_alu_regs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_ALU) && instr_valid_i |-> rf_waddr_o == exp_rd && rf_ren_a_o
    && (rf_ren_b_o == exp_ren_b))
    else report_error("ALU write address or register read enables wrong");

  a_alu_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_ALU) && instr_valid_i |-> instr_done_o && rf_we_o && !illegal_insn_o)
    else report_error("ALU instruction not done with a register write in its cycle");

  a_illegal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_ILL) && instr_valid_i |-> illegal_insn_o && !rf_we_o && !lsu_req_o)
    else report_error("invalid opcode not flagged or still writes or requests");

  // Branches
  a_br_not_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_BR_NT) && instr_valid_i |-> instr_done_o && !pc_set_o)
    else report_error("not-taken branch did not complete without a PC set");

  a_br_taken_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_BR_T) && first_cycle_o |-> !pc_set_o && !instr_done_o)
    else report_error("taken branch set PC or completed in its first cycle");

  a_br_taken_second: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_BR_T) && first_cycle_o |=> pc_set_o && !pc_sel_o && instr_done_o)
    else report_error("taken branch missed its branch PC set and completion");

  // JAL, target first, link value second
  a_jal_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_JAL) && first_cycle_o |-> pc_set_o && pc_sel_o && !instr_done_o)
    else report_error("JAL first cycle without a jump PC set or completed early");

  a_jal_op_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_JAL) && first_cycle_o |-> alu_op_a_o == exp_a)
    else report_mismatch("alu_op_a_o", alu_op_a_o, exp_a);

  a_jal_op_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_JAL) && first_cycle_o |-> alu_op_b_o == exp_b)
    else report_mismatch("alu_op_b_o", alu_op_b_o, exp_b);

  a_jal_link: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_JAL) && instr_valid_i && !first_cycle_o |-> alu_op_b_o == `ID_INSN_STEP)
    else report_mismatch("alu_op_b_o", alu_op_b_o, `ID_INSN_STEP);

  a_jal_second: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_JAL) && instr_valid_i && !first_cycle_o |-> !pc_set_o && rf_we_o
    && instr_done_o)
    else report_error("JAL second cycle without link write and completion");

  // LSU four-phase handshake and data
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_o && !lsu_ack_i |=> lsu_req_o)
    else report_error("lsu_req_o dropped before ack");

  a_req_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(lsu_req_o) |-> !lsu_ack_i)
    else report_error("lsu_req_o raised while ack still high");

  a_lsu_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_LD || mode == T_ST) && instr_done_o |-> lsu_ack_i && lsu_req_o
    && (rf_we_o == (mode == T_LD)))
    else report_error("memory instruction done without ack or with wrong write enable");

  a_lsu_payload: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_LD || mode == T_ST) && lsu_req_o |-> (lsu_req_data_o.we == (mode == T_ST))
    && (lsu_req_data_o.dtype == exp_dtype)
    && ((mode == T_ST) || (lsu_req_data_o.sign_ext == exp_sext)))
    else report_error("LSU request has wrong direction, size or sign extension");

  a_store_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_ST) && lsu_req_o |-> lsu_req_data_o.wdata == exp_store)
    else report_mismatch("lsu_req_data_o.wdata", lsu_req_data_o.wdata, exp_store);

  a_load_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode == T_LD) && rf_we_o |-> rf_wdata_o == exp_rdata)
    else report_mismatch("rf_wdata_o", rf_wdata_o, exp_rdata);

  ////////////////////
  // Stimulus
  ////////////////////

  // Called at a falling edge, holds the instruction until ready
  task automatic run_insn(input insn_t ins, input word_t pc, input logic gap);
    instr_valid_i = 1'b1;
    instr_i       = ins;
    pc_id_i       = pc;
    do begin
      @(posedge clk_i);
    end while (!id_in_ready_o);
    @(negedge clk_i);
    if (gap) begin
      instr_valid_i = 1'b0;
      @(negedge clk_i);
    end
    insn_cnt++;
  endtask

  task automatic test_alu();
    insn_t      ins;
    logic [2:0] f3;
    logic [6:0] f7;
    int         e0;
    e0   = err_cnt;
    mode = T_ALU;
    repeat (N_ALU) begin
      ins = $random(seed);
      f3  = ins[14:12];
      // SUB and SRA/SRAI are the only alternate encodings
      f7  = ((f3 == 3'b000 || f3 == 3'b101) && ins[30]) ? 7'h20 : 7'h00;
      if (ins[0]) begin
        ins       = {f7, ins[24:7], `ID_OPC_OP};
        exp_b     = rf_word(ins[24:20]);
        exp_op    = alu_op_for(f3, f7 == 7'h20);
        exp_ren_b = 1'b1;
      end else begin
        if (f3 == 3'b001 || f3 == 3'b101) ins[31:25] = f7;
        ins       = {ins[31:7], `ID_OPC_OP_IMM};
        exp_b     = i_type_imm(ins);
        exp_op    = alu_op_for(f3, (f3 == 3'b101) && (f7 == 7'h20));
        exp_ren_b = 1'b0;
      end
      exp_a       = rf_word(ins[19:15]);
      exp_rd      = ins[11:7];
      exp_wdata   = $random(seed);
      result_ex_i = exp_wdata;
      run_insn(ins, $random(seed), 1'b1);
    end
    report_test("alu", N_ALU, e0);
  endtask

  task automatic test_illegal();
    insn_t ins;
    int    e0;
    e0   = err_cnt;
    mode = T_ILL;
    repeat (N_ILL) begin
      ins = $random(seed);
      while (ins[6:0] inside {`ID_OPC_OP, `ID_OPC_OP_IMM, `ID_OPC_LUI, `ID_OPC_AUIPC,
                              `ID_OPC_LOAD, `ID_OPC_STORE, `ID_OPC_BRANCH, `ID_OPC_JAL}) begin
        ins[6:0] = 7'($random(seed));
      end
      run_insn(ins, $random(seed), 1'b1);
    end
    report_test("illegal", N_ILL, e0);
  endtask

  task automatic test_branch();
    insn_t      ins;
    logic [2:0] f3;
    int         e0;
    e0 = err_cnt;
    for (int i = 0; i < N_BR; i++) begin
      ins = $random(seed);
      f3  = ins[14:12];
      // funct3 010 and 011 are reserved
      if (f3[2:1] == 2'b01) f3[2] = 1'b1;
      ins               = {ins[31:15], f3, ins[11:7], `ID_OPC_BRANCH};
      mode              = i[0] ? T_BR_T : T_BR_NT;
      branch_decision_i = i[0];
      run_insn(ins, $random(seed), 1'b1);
    end
    branch_decision_i = 1'b0;
    report_test("branch", N_BR, e0);
  endtask

  task automatic test_jal();
    insn_t ins;
    word_t pc;
    int    e0;
    e0   = err_cnt;
    mode = T_JAL;
    repeat (N_JAL) begin
      ins     = {$random(seed)};
      ins     = {ins[31:7], `ID_OPC_JAL};
      pc      = $random(seed);
      pc[1:0] = 2'b00;
      exp_a   = pc;
      exp_b   = j_type_imm(ins);
      run_insn(ins, pc, 1'b1);
    end
    report_test("jal", N_JAL, e0);
  endtask

  // Back to back, so a stale ack meets the next request
  task automatic test_lsu();
    insn_t      ins;
    logic [2:0] f3;
    int         e0;
    e0 = err_cnt;
    repeat (N_LSU) begin
      ins       = $random(seed);
      f3        = ins[14:12];
      ack_delay = 1 + ($unsigned($random(seed)) % 4);
      if (ins[31]) begin
        f3[2] = 1'b0;
        if (f3 == 3'b011) f3 = 3'b010;
        ins       = {ins[31:15], f3, ins[11:7], `ID_OPC_STORE};
        exp_store = rf_word(ins[24:20]);
        mode      = T_ST;
      end else begin
        if (f3 == 3'b011 || f3[2:1] == 2'b11) f3 = 3'b010;
        ins         = {ins[31:15], f3, ins[11:7], `ID_OPC_LOAD};
        exp_rdata   = $random(seed);
        lsu_rdata_i = exp_rdata;
        mode        = T_LD;
      end
      exp_dtype = lsu_size(f3[1:0]);
      exp_sext  = ~f3[2];
      run_insn(ins, $random(seed), 1'b0);
    end
    report_test("lsu", N_LSU, e0);
  endtask

  initial begin : stimulus
    seed              = 32'h338da1b4;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_i           = '0;
    pc_id_i           = '0;
    branch_decision_i = 1'b0;
    result_ex_i       = '0;
    lsu_rdata_i       = '0;
    ack_delay         = 1;
    mode              = T_IDLE;
    rst_chk           = 1'b0;
    err_cnt           = 0;
    insn_cnt          = 0;
    tests_run         = 0;
    // Reset held for RST_CYCLES, one quiet cycle checked after release
    @(negedge clk_i);
    rst_chk = 1'b1;
    repeat (RST_CYCLES - 1) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    rst_chk = 1'b0;
    report_test("reset", 0, 0);
    test_alu();
    test_illegal();
    test_branch();
    test_jal();
    test_lsu();
    mode          = T_IDLE;
    instr_valid_i = 1'b0;
    repeat (4) @(negedge clk_i);
    $display("summary: %0d tests, %0d instructions, %0d errors", tests_run, insn_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // At most 10 cycles per instruction
  initial begin : watchdog
    repeat ((N_TOTAL + RST_CYCLES) * 10) @(posedge clk_i);
    $display("timeout: stimulus did not finish after %0d instructions", insn_cnt);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_mux.sv
rtl/id_controller.sv
rtl/id_stage.sv
dv/tb_id_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_id_stage -f vlog.f -o sim_id_stage
./obj_dir/sim_id_stage | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
grep -q "TEST PASS" sim.log
